// File: loader_pkg.sv
/* Shared widths, types and constants of the download loader.
   Every loader module refers to these by scoped name. */

package loader_pkg;

	// ============================================================
	// Widths and types
	// ============================================================
	localparam int BYTE_W     = 8;
	localparam int WORD_W     = 16;
	localparam int MEM_ADDR_W = 25;
	localparam int BLK_LEN_W  = 32;
	localparam int HDR_IDX_W  = 4;
	localparam int ALIGN_BITS = 13;

	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [BLK_LEN_W-1:0]  blk_len_t;
	typedef logic [HDR_IDX_W-1:0]  hdr_idx_t;
	typedef logic [7:0]            file_index_t;

	typedef enum logic [2:0] {
		IDLE, PRG_HDR, PRG_DATA, CRT_FILE_HDR, CRT_CHIP, INJECT, ERASE
	} load_state_t;

	typedef enum logic [2:0] {
		HOLD, SET_LO, SET_HI, SET_CRT_BASE, ALIGN_8K, CLEAR, INC
	} addr_cmd_t;

	typedef enum logic [1:0] {
		SRC_DOWNLOAD, SRC_INJECT, SRC_ERASE
	} data_src_t;

	// ============================================================
	// File formats and memory map
	// ============================================================
	localparam file_index_t IDX_PRG = 8'd4;
	localparam file_index_t IDX_CRT = 8'd5;

	localparam mem_addr_t CRT_BASE       = 25'h100000;
	localparam mem_addr_t CRT_CHIP_START = 25'h40;
	localparam blk_len_t  CRT_HDR_BYTES  = 32'd16;
	localparam hdr_idx_t  HDR_LAST       = hdr_idx_t'(CRT_HDR_BYTES - 1);
	// First character of the "C64 CARTRIDGE" signature
	localparam byte_t     CRT_SIG        = 8'h43;

	localparam mem_addr_t OFS_ID_HI = 25'h16;
	localparam mem_addr_t OFS_ID_LO = 25'h17;
	localparam mem_addr_t OFS_EXROM = 25'h18;
	localparam mem_addr_t OFS_GAME  = 25'h19;

	localparam mem_addr_t ERASE_LAST  = 25'hFFFF;
	localparam int        ERASE_GAP   = 32;
	localparam int        STRIPE_BIT  = 6;
	localparam mem_addr_t INJECT_LAST = 25'hFF;

endpackage

// File: chip_packet_counter.sv
/* Tracks position inside CRT chip packets: header byte index, then the
   remaining data bytes taken from the big-endian packet length. */

module chip_packet_counter (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 start_i,
	input  logic                 chip_byte_i,
	input  loader_pkg::byte_t    data_i,
	output loader_pkg::hdr_idx_t hdr_idx_o,
	output logic                 in_hdr_o,
	output logic                 pkt_first_o
);
	loader_pkg::hdr_idx_t hdr_cnt;
	loader_pkg::blk_len_t blk_len;

	// Index zero doubles as "outside a header"
	assign hdr_idx_o   = hdr_cnt;
	assign in_hdr_o    = hdr_cnt != '0;
	assign pkt_first_o = !in_hdr_o && blk_len == '0;

	always_ff @(posedge clk_sys) begin
		if (RESET || start_i) begin
			hdr_cnt <= '0;
			blk_len <= '0;
		end else if (chip_byte_i) begin
			if (pkt_first_o) begin
				hdr_cnt <= loader_pkg::hdr_idx_t'(1);
			end else if (in_hdr_o) begin
				// Wraps to zero after the last header byte
				hdr_cnt <= hdr_cnt + 1'b1;
				case (hdr_cnt)
					4'd4: blk_len[31:24] <= data_i;
					4'd5: blk_len[23:16] <= data_i;
					4'd6: blk_len[15:8]  <= data_i;
					4'd7: blk_len[7:0]   <= data_i;
					4'd8: blk_len        <= blk_len - loader_pkg::CRT_HDR_BYTES;
					default: ;
				endcase
			end else begin
				blk_len <= blk_len - 1'b1;
			end
		end
	end

endmodule

// File: crt_header_regs.sv
/* Cartridge header registers. Holds the file-header fields and the fields
   of the current chip packet, and pulses bank_wr_o when a chip header is complete. */

module crt_header_regs (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 dl_wr_i,
	input  loader_pkg::mem_addr_t dl_addr_i,
	input  loader_pkg::byte_t    dl_data_i,
	input  logic                 crt_file_i,
	input  loader_pkg::hdr_idx_t hdr_idx_i,
	input  logic                 in_hdr_i,
	output loader_pkg::word_t    cart_id_o,
	output loader_pkg::byte_t    cart_exrom_o,
	output loader_pkg::byte_t    cart_game_o,
	output loader_pkg::byte_t    bank_type_o,
	output loader_pkg::word_t    bank_num_o,
	output loader_pkg::word_t    bank_laddr_o,
	output loader_pkg::word_t    bank_size_o,
	output logic                 bank_wr_o
);
	logic file_wr;
	logic chip_hdr_wr;

	assign file_wr     = dl_wr_i && crt_file_i;
	assign chip_hdr_wr = file_wr && in_hdr_i && dl_addr_i >= loader_pkg::CRT_CHIP_START;

	// File header fields, big-endian
	always_ff @(posedge clk_sys) begin
		if (file_wr) begin
			case (dl_addr_i)
				loader_pkg::OFS_ID_HI: cart_id_o[15:8] <= dl_data_i;
				loader_pkg::OFS_ID_LO: cart_id_o[7:0]  <= dl_data_i;
				loader_pkg::OFS_EXROM: cart_exrom_o    <= dl_data_i;
				loader_pkg::OFS_GAME:  cart_game_o     <= dl_data_i;
				default: ;
			endcase
		end
	end

	// Chip packet fields
	always_ff @(posedge clk_sys) begin
		if (chip_hdr_wr) begin
			case (hdr_idx_i)
				4'd9:  bank_type_o        <= dl_data_i;
				4'd10: bank_num_o[15:8]   <= dl_data_i;
				4'd11: bank_num_o[7:0]    <= dl_data_i;
				4'd12: bank_laddr_o[15:8] <= dl_data_i;
				4'd13: bank_laddr_o[7:0]  <= dl_data_i;
				4'd14: bank_size_o[15:8]  <= dl_data_i;
				4'd15: bank_size_o[7:0]   <= dl_data_i;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			bank_wr_o <= 1'b0;
		else
			bank_wr_o <= chip_hdr_wr && hdr_idx_i == loader_pkg::HDR_LAST;
	end

endmodule

// File: basic_ptr_table.sv
/* BASIC pointer table for program injection. Takes the program end address
   at injection start and returns the pointer byte for each zero-page slot. */

module basic_ptr_table (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  inject_start_i,
	input  loader_pkg::mem_addr_t cur_addr_i,
	output logic                  ptr_hit_o,
	output loader_pkg::byte_t     ptr_data_o
);
	loader_pkg::word_t end_addr;

	always_ff @(posedge clk_sys) begin
		if (RESET)
			end_addr <= '0;
		else if (inject_start_i)
			end_addr <= cur_addr_i[15:0];
	end

	always_comb begin
		ptr_hit_o  = 1'b1;
		ptr_data_o = '0;
		case (cur_addr_i[7:0])
			// TXT start, as after a cold start
			8'h2B: ptr_data_o = 8'h01;
			8'h2C: ptr_data_o = 8'h08;
			8'hAC, 8'hAD: ptr_data_o = 8'h00;
			// VAR, ARY, STR and LOAD_END all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data_o = end_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data_o = end_addr[15:8];
			default: ptr_hit_o = 1'b0;
		endcase
		if (cur_addr_i[24:8] != '0)
			ptr_hit_o = 1'b0;
	end

endmodule

// File: mem_write_port.sv
/* Memory write port. Keeps the running load address and one outstanding
   write, held on the memory bus until mem_ack_i. */

module mem_write_port (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  loader_pkg::addr_cmd_t addr_cmd_i,
	input  loader_pkg::data_src_t data_src_i,
	input  logic                  wr_req_i,
	input  loader_pkg::byte_t     dl_data_i,
	input  loader_pkg::byte_t     ptr_data_i,
	input  logic                  mem_ack_i,
	output logic                  pending_o,
	output loader_pkg::mem_addr_t cur_addr_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o
);
	loader_pkg::byte_t src_data;

	always_comb begin
		case (data_src_i)
			loader_pkg::SRC_INJECT: src_data = ptr_data_i;
			// 64-byte stripes of 00 and FF
			loader_pkg::SRC_ERASE:
				src_data = {$bits(loader_pkg::byte_t){cur_addr_o[loader_pkg::STRIPE_BIT]}};
			default: src_data = dl_data_i;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pending_o  <= 1'b0;
			cur_addr_o <= '0;
		end else begin
			if (wr_req_i)
				pending_o <= 1'b1;
			else if (mem_ack_i)
				pending_o <= 1'b0;

			case (addr_cmd_i)
				loader_pkg::SET_LO:
					cur_addr_o <= loader_pkg::mem_addr_t'({cur_addr_o[15:8], dl_data_i});
				loader_pkg::SET_HI:       cur_addr_o[15:8] <= dl_data_i;
				loader_pkg::SET_CRT_BASE: cur_addr_o <= loader_pkg::CRT_BASE;
				loader_pkg::ALIGN_8K: begin
					if (cur_addr_o[loader_pkg::ALIGN_BITS-1:0] != '0)
						cur_addr_o <= {cur_addr_o[24:loader_pkg::ALIGN_BITS] + 1'b1,
							{loader_pkg::ALIGN_BITS{1'b0}}};
				end
				loader_pkg::CLEAR: cur_addr_o <= '0;
				loader_pkg::INC:   cur_addr_o <= cur_addr_o + 1'b1;
				default: begin
					// Step past the write that was just accepted
					if (pending_o && mem_ack_i)
						cur_addr_o <= cur_addr_o + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_req_i) begin
			mem_addr_o <= cur_addr_o;
			mem_data_o <= src_data;
		end
	end

	assign mem_we_o = pending_o;

endmodule

// File: load_sequencer.sv
/* Download sequencer. Decodes each host byte by file type and offset, drives
   the address commands and write requests, and runs injection and RAM erase. */

module load_sequencer (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active_i,
	input  loader_pkg::file_index_t dl_index_i,
	input  logic                    dl_wr_i,
	input  loader_pkg::mem_addr_t   dl_addr_i,
	input  loader_pkg::byte_t       dl_data_i,
	input  logic                    erase_req_i,
	input  logic                    in_hdr_i,
	input  logic                    pkt_first_i,
	input  logic                    ptr_hit_i,
	input  logic                    pending_i,
	input  loader_pkg::mem_addr_t   cur_addr_i,
	output loader_pkg::addr_cmd_t   addr_cmd_o,
	output loader_pkg::data_src_t   data_src_o,
	output logic                    wr_req_o,
	output logic                    chip_byte_o,
	output logic                    inject_start_o,
	output logic                    cart_attached_o,
	output logic                    busy_o,
	output logic                    dl_wait_o
);
	localparam int GAP_W = $clog2(loader_pkg::ERASE_GAP);

	loader_pkg::load_state_t state_q;
	logic [GAP_W-1:0]        gap_cnt;
	logic                    sig_ok;
	logic                    prg_wr;
	logic                    prg_hdr_wr;
	logic                    crt_wr;
	logic                    data_wr;
	logic                    port_idle;
	logic                    inj_step;
	logic                    inj_live;
	logic                    erase_start;
	logic                    erase_go;

	// ============================================================
	// Byte decode and commands
	// ============================================================
	always_comb begin
		prg_wr = dl_active_i && dl_wr_i && dl_index_i == loader_pkg::IDX_PRG &&
			(state_q == loader_pkg::IDLE || state_q == loader_pkg::PRG_HDR ||
			 state_q == loader_pkg::PRG_DATA);
		prg_hdr_wr = prg_wr && state_q != loader_pkg::PRG_DATA;
		crt_wr = dl_active_i && dl_wr_i && dl_index_i == loader_pkg::IDX_CRT &&
			(state_q == loader_pkg::IDLE || state_q == loader_pkg::CRT_FILE_HDR ||
			 state_q == loader_pkg::CRT_CHIP);
		chip_byte_o = crt_wr && dl_addr_i >= loader_pkg::CRT_CHIP_START;
		// Chip header bytes only feed the counter and header registers
		data_wr = (prg_wr && state_q == loader_pkg::PRG_DATA) ||
			(chip_byte_o && !pkt_first_i && !in_hdr_i);
		port_idle   = !wr_req_o && !pending_i;
		inj_step    = state_q == loader_pkg::INJECT && !inject_start_o && port_idle;
		inj_live    = cur_addr_i <= loader_pkg::INJECT_LAST;
		erase_start = state_q == loader_pkg::IDLE && erase_req_i && !dl_active_i;
		erase_go    = state_q == loader_pkg::ERASE && port_idle &&
			gap_cnt == GAP_W'(loader_pkg::ERASE_GAP - 1);

		addr_cmd_o = loader_pkg::HOLD;
		if (prg_hdr_wr && dl_addr_i == '0)
			addr_cmd_o = loader_pkg::SET_LO;
		else if (prg_hdr_wr && dl_addr_i == loader_pkg::mem_addr_t'(1))
			addr_cmd_o = loader_pkg::SET_HI;
		else if (crt_wr && dl_addr_i == '0)
			addr_cmd_o = loader_pkg::SET_CRT_BASE;
		else if (chip_byte_o && pkt_first_i)
			addr_cmd_o = loader_pkg::ALIGN_8K;
		else if (erase_start || inject_start_o)
			addr_cmd_o = loader_pkg::CLEAR;
		else if (inj_step && inj_live && !ptr_hit_i)
			addr_cmd_o = loader_pkg::INC;

		case (state_q)
			loader_pkg::INJECT: data_src_o = loader_pkg::SRC_INJECT;
			loader_pkg::ERASE:  data_src_o = loader_pkg::SRC_ERASE;
			default:            data_src_o = loader_pkg::SRC_DOWNLOAD;
		endcase
	end

	assign busy_o    = state_q == loader_pkg::INJECT || state_q == loader_pkg::ERASE;
	assign dl_wait_o = wr_req_o || pending_i || busy_o;

	// ============================================================
	// State machine
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q         <= loader_pkg::IDLE;
			wr_req_o        <= 1'b0;
			inject_start_o  <= 1'b0;
			cart_attached_o <= 1'b0;
			gap_cnt         <= '0;
			sig_ok          <= 1'b0;
		end else begin
			wr_req_o <= data_wr || (inj_step && inj_live && ptr_hit_i) ||
				(erase_go && cur_addr_i <= loader_pkg::ERASE_LAST);
			inject_start_o <= 1'b0;
			if (crt_wr && dl_addr_i == '0)
				sig_ok <= dl_data_i == loader_pkg::CRT_SIG;

			case (state_q)
				loader_pkg::IDLE: begin
					if (erase_start) begin
						state_q <= loader_pkg::ERASE;
						gap_cnt <= '0;
					end else if (dl_active_i && dl_index_i == loader_pkg::IDX_PRG) begin
						state_q <= loader_pkg::PRG_HDR;
					end else if (dl_active_i && dl_index_i == loader_pkg::IDX_CRT) begin
						state_q         <= loader_pkg::CRT_FILE_HDR;
						cart_attached_o <= 1'b0;
					end
				end
				loader_pkg::PRG_HDR, loader_pkg::PRG_DATA: begin
					// Last data write must land before the end address is taken
					if (!dl_active_i && port_idle) begin
						state_q        <= loader_pkg::INJECT;
						inject_start_o <= 1'b1;
					end else if (prg_hdr_wr && dl_addr_i == loader_pkg::mem_addr_t'(1)) begin
						state_q <= loader_pkg::PRG_DATA;
					end
				end
				loader_pkg::CRT_FILE_HDR, loader_pkg::CRT_CHIP: begin
					if (!dl_active_i && port_idle) begin
						state_q         <= loader_pkg::IDLE;
						cart_attached_o <= sig_ok;
					end else if (chip_byte_o) begin
						state_q <= loader_pkg::CRT_CHIP;
					end
				end
				loader_pkg::INJECT: begin
					if (inj_step && !inj_live)
						state_q <= loader_pkg::IDLE;
				end
				loader_pkg::ERASE: begin
					if (port_idle)
						gap_cnt <= gap_cnt + 1'b1;
					if (erase_go) begin
						gap_cnt <= '0;
						if (cur_addr_i > loader_pkg::ERASE_LAST)
							state_q <= loader_pkg::IDLE;
					end
				end
				default: state_q <= loader_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: loader_top.sv
/* Download loader top level. Connects sequencer, chip counter, cartridge
   header registers, BASIC pointer table and memory write port. */

module loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active_i,
	input  loader_pkg::file_index_t dl_index_i,
	input  logic                    dl_wr_i,
	input  loader_pkg::mem_addr_t   dl_addr_i,
	input  loader_pkg::byte_t       dl_data_i,
	output logic                    dl_wait_o,
	input  logic                    erase_req_i,
	output logic                    mem_we_o,
	output loader_pkg::mem_addr_t   mem_addr_o,
	output loader_pkg::byte_t       mem_data_o,
	input  logic                    mem_ack_i,
	output loader_pkg::word_t       cart_id_o,
	output loader_pkg::byte_t       cart_exrom_o,
	output loader_pkg::byte_t       cart_game_o,
	output logic                    cart_attached_o,
	output loader_pkg::byte_t       bank_type_o,
	output loader_pkg::word_t       bank_num_o,
	output loader_pkg::word_t       bank_laddr_o,
	output loader_pkg::word_t       bank_size_o,
	output logic                    bank_wr_o,
	output logic                    busy_o
);
	loader_pkg::addr_cmd_t addr_cmd;
	loader_pkg::data_src_t data_src;
	loader_pkg::hdr_idx_t  hdr_idx;
	loader_pkg::byte_t     ptr_data;
	loader_pkg::mem_addr_t cur_addr;
	logic                  wr_req;
	logic                  chip_byte;
	logic                  inject_start;
	logic                  in_hdr;
	logic                  pkt_first;
	logic                  ptr_hit;
	logic                  pending;
	logic                  crt_file;
	logic                  crt_start;

	assign crt_file  = dl_active_i && dl_index_i == loader_pkg::IDX_CRT;
	// Counter restarts with the cartridge base address
	assign crt_start = addr_cmd == loader_pkg::SET_CRT_BASE;

	load_sequencer u_seq (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i), .erase_req_i(erase_req_i),
		.in_hdr_i(in_hdr), .pkt_first_i(pkt_first), .ptr_hit_i(ptr_hit),
		.pending_i(pending), .cur_addr_i(cur_addr),
		.addr_cmd_o(addr_cmd), .data_src_o(data_src), .wr_req_o(wr_req),
		.chip_byte_o(chip_byte), .inject_start_o(inject_start),
		.cart_attached_o(cart_attached_o), .busy_o(busy_o), .dl_wait_o(dl_wait_o)
	);

	chip_packet_counter u_cnt (
		.clk_sys(clk_sys), .RESET(RESET), .start_i(crt_start),
		.chip_byte_i(chip_byte), .data_i(dl_data_i),
		.hdr_idx_o(hdr_idx), .in_hdr_o(in_hdr), .pkt_first_o(pkt_first)
	);

	crt_header_regs u_hdr (
		.clk_sys(clk_sys), .RESET(RESET), .dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i), .crt_file_i(crt_file), .hdr_idx_i(hdr_idx),
		.in_hdr_i(in_hdr), .cart_id_o(cart_id_o), .cart_exrom_o(cart_exrom_o),
		.cart_game_o(cart_game_o), .bank_type_o(bank_type_o), .bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o), .bank_size_o(bank_size_o), .bank_wr_o(bank_wr_o)
	);

	basic_ptr_table u_ptr (
		.clk_sys(clk_sys), .RESET(RESET), .inject_start_i(inject_start),
		.cur_addr_i(cur_addr), .ptr_hit_o(ptr_hit), .ptr_data_o(ptr_data)
	);

	mem_write_port u_port (
		.clk_sys(clk_sys), .RESET(RESET), .addr_cmd_i(addr_cmd), .data_src_i(data_src),
		.wr_req_i(wr_req), .dl_data_i(dl_data_i), .ptr_data_i(ptr_data),
		.mem_ack_i(mem_ack_i), .pending_o(pending), .cur_addr_o(cur_addr),
		.mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o)
	);

endmodule

// File: tb_loader.sv
/* Self-checking testbench for the download loader. Applies a table of PRG,
   CRT and erase jobs through the host port and checks a behavioural memory. */

module tb_loader;

	localparam loader_pkg::file_index_t ERASE_KIND = 8'h00;
	localparam int ROWS      = 4;
	localparam int HOST_TMO  = 200;
	localparam int BUSY_TMO  = 4000000;

	typedef struct packed {
		loader_pkg::file_index_t kind;
		loader_pkg::word_t       load;
		loader_pkg::word_t       count;
		loader_pkg::byte_t       seed;
		loader_pkg::word_t       id;
		loader_pkg::byte_t       exrom;
		loader_pkg::byte_t       game;
		loader_pkg::byte_t       btype;
		loader_pkg::byte_t       npkt;
	} row_t;

	logic                    clk_sys = 1'b0;
	logic                    RESET;
	logic                    dl_active_i;
	loader_pkg::file_index_t dl_index_i;
	logic                    dl_wr_i;
	loader_pkg::mem_addr_t   dl_addr_i;
	loader_pkg::byte_t       dl_data_i;
	logic                    dl_wait_o;
	logic                    erase_req_i;
	logic                    mem_we_o;
	loader_pkg::mem_addr_t   mem_addr_o;
	loader_pkg::byte_t       mem_data_o;
	logic                    mem_ack_i;
	loader_pkg::word_t       cart_id_o;
	loader_pkg::byte_t       cart_exrom_o;
	loader_pkg::byte_t       cart_game_o;
	logic                    cart_attached_o;
	loader_pkg::byte_t       bank_type_o;
	loader_pkg::word_t       bank_num_o;
	loader_pkg::word_t       bank_laddr_o;
	loader_pkg::word_t       bank_size_o;
	logic                    bank_wr_o;
	logic                    busy_o;

	row_t rows [ROWS];

	// Behavioural memory and write bookkeeping
	loader_pkg::byte_t     mem_q [loader_pkg::mem_addr_t];
	int                    wr_cnt [loader_pkg::mem_addr_t];
	int                    total_wr;
	logic                  seen;
	int                    delay;
	loader_pkg::mem_addr_t held_addr;
	loader_pkg::byte_t     held_data;

	loader_pkg::byte_t bt_q[$];
	loader_pkg::word_t bn_q[$];
	loader_pkg::word_t bl_q[$];
	loader_pkg::word_t bs_q[$];

	loader_top uut (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i), .dl_wait_o(dl_wait_o), .erase_req_i(erase_req_i),
		.mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
		.mem_ack_i(mem_ack_i), .cart_id_o(cart_id_o), .cart_exrom_o(cart_exrom_o),
		.cart_game_o(cart_game_o), .cart_attached_o(cart_attached_o),
		.bank_type_o(bank_type_o), .bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o), .bank_size_o(bank_size_o),
		.bank_wr_o(bank_wr_o), .busy_o(busy_o)
	);

	always #10 clk_sys = ~clk_sys;

	// ============================================================
	// Failure reporting and compares
	// ============================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_byte(input string name, input loader_pkg::byte_t got,
			input loader_pkg::byte_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_word(input string name, input loader_pkg::word_t got,
			input loader_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_addr(input string name, input loader_pkg::mem_addr_t got,
			input loader_pkg::mem_addr_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_once(input loader_pkg::mem_addr_t a, input loader_pkg::byte_t exp);
		if (!wr_cnt.exists(a)) begin
			abort_run($sformatf("no memory write reached address %h", a));
		end else begin
			check_addr("writes per address", loader_pkg::mem_addr_t'(wr_cnt[a]),
				loader_pkg::mem_addr_t'(1));
			check_byte("mem_data_o", mem_q[a], exp);
		end
	endtask

	// ============================================================
	// Memory responder with random acknowledge delay
	// ============================================================
	initial begin
		void'($urandom(68));
		forever begin
			@(negedge clk_sys);
			if (mem_we_o === 1'b1) begin
				if (!seen) begin
					held_addr = mem_addr_o;
					held_data = mem_data_o;
					seen      = 1'b1;
					delay     = $urandom_range(3, 0);
				end
				// Request must not move while it waits for the acknowledge
				check_addr("mem_addr_o", mem_addr_o, held_addr);
				check_byte("mem_data_o", mem_data_o, held_data);
				if (delay == 0) begin
					mem_q[held_addr] = held_data;
					if (wr_cnt.exists(held_addr))
						wr_cnt[held_addr] = wr_cnt[held_addr] + 1;
					else
						wr_cnt[held_addr] = 1;
					total_wr = total_wr + 1;
					@(posedge clk_sys);
					mem_ack_i <= 1'b1;
					@(posedge clk_sys);
					mem_ack_i <= 1'b0;
					seen = 1'b0;
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

	always @(negedge clk_sys) begin
		if (bank_wr_o === 1'b1) begin
			bt_q.push_back(bank_type_o);
			bn_q.push_back(bank_num_o);
			bl_q.push_back(bank_laddr_o);
			bs_q.push_back(bank_size_o);
		end
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================
	function automatic loader_pkg::byte_t data_at(input loader_pkg::byte_t seed, input int k);
		return seed + loader_pkg::byte_t'(k * 3);
	endfunction

	// BASIC pointer bytes expected in the zero page after a program load
	function automatic bit ptr_expect(input int a, input loader_pkg::word_t end_a,
			output loader_pkg::byte_t val);
		val = 8'h00;
		case (a)
			'h2B: val = 8'h01;
			'h2C: val = 8'h08;
			'hAC, 'hAD: val = 8'h00;
			'h2D, 'h2F, 'h31, 'hAE: val = end_a[7:0];
			'h2E, 'h30, 'h32, 'hAF: val = end_a[15:8];
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	function automatic loader_pkg::byte_t file_hdr_byte(input int ofs, input row_t r);
		case (ofs)
			0:    return 8'h43;
			'h16: return r.id[15:8];
			'h17: return r.id[7:0];
			'h18: return r.exrom;
			'h19: return r.game;
			default: return 8'h00;
		endcase
	endfunction

	function automatic loader_pkg::byte_t chip_hdr_byte(input int i, input row_t r, input int p);
		loader_pkg::blk_len_t len;
		loader_pkg::word_t    bank;
		len  = 32'd16 + loader_pkg::blk_len_t'(r.count);
		bank = loader_pkg::word_t'(p);
		case (i)
			0: return 8'h43;
			1: return 8'h48;
			2: return 8'h49;
			3: return 8'h50;
			4: return len[31:24];
			5: return len[23:16];
			6: return len[15:8];
			7: return len[7:0];
			9: return r.btype;
			10: return bank[15:8];
			11: return bank[7:0];
			12: return r.load[15:8];
			13: return r.load[7:0];
			14: return r.count[15:8];
			15: return r.count[7:0];
			default: return 8'h00;
		endcase
	endfunction

	function automatic row_t make_row(input loader_pkg::file_index_t kind,
			input loader_pkg::word_t load, input loader_pkg::word_t count,
			input loader_pkg::byte_t seed, input loader_pkg::byte_t npkt);
		row_t r;
		r       = '0;
		r.kind  = kind;
		r.load  = load;
		r.count = count;
		r.seed  = seed;
		r.npkt  = npkt;
		return r;
	endfunction

	task automatic clear_mem();
		mem_q.delete();
		wr_cnt.delete();
		total_wr = 0;
	endtask

	task automatic host_write(input int ofs, input loader_pkg::byte_t data);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (dl_wait_o !== 1'b0) begin
			t = t + 1;
			if (t > HOST_TMO)
				abort_run("host write timed out, dl_wait_o stayed high");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= loader_pkg::mem_addr_t'(ofs);
		dl_data_i <= data;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (busy_o !== level) begin
			t = t + 1;
			if (t > limit)
				abort_run($sformatf("timed out waiting for busy_o to become %0b", level));
			@(negedge clk_sys);
		end
	endtask

	// ============================================================
	// Jobs
	// ============================================================
	task automatic run_erase();
		loader_pkg::mem_addr_t a;
		clear_mem();
		@(posedge clk_sys);
		erase_req_i <= 1'b1;
		@(posedge clk_sys);
		erase_req_i <= 1'b0;
		wait_busy(1'b1, 10);
		wait_busy(1'b0, BUSY_TMO);
		for (int i = 0; i <= 'hFFFF; i++) begin
			a = loader_pkg::mem_addr_t'(i);
			check_once(a, a[loader_pkg::STRIPE_BIT] ? 8'hFF : 8'h00);
		end
		check_addr("erase write count", loader_pkg::mem_addr_t'(total_wr), 25'h10000);
	endtask

	task automatic run_prg(input row_t r);
		loader_pkg::word_t end_a;
		loader_pkg::byte_t val;
		int hits;
		clear_mem();
		hits = 0;
		@(posedge clk_sys);
		dl_index_i  <= loader_pkg::IDX_PRG;
		dl_active_i <= 1'b1;
		host_write(0, r.load[7:0]);
		host_write(1, r.load[15:8]);
		for (int k = 0; k < int'(r.count); k++)
			host_write(2 + k, data_at(r.seed, k));
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		wait_busy(1'b1, HOST_TMO);
		wait_busy(1'b0, 20000);
		end_a = r.load + r.count;
		for (int k = 0; k < int'(r.count); k++)
			check_once(loader_pkg::mem_addr_t'(r.load + loader_pkg::word_t'(k)),
				data_at(r.seed, k));
		for (int a = 0; a < 256; a++) begin
			if (ptr_expect(a, end_a, val)) begin
				check_once(loader_pkg::mem_addr_t'(a), val);
				hits = hits + 1;
			end else if (wr_cnt.exists(loader_pkg::mem_addr_t'(a))) begin
				abort_run($sformatf("injection wrote a non-pointer address %h", a));
			end
		end
		check_addr("prg write count", loader_pkg::mem_addr_t'(total_wr),
			loader_pkg::mem_addr_t'(int'(r.count) + hits));
	endtask

	task automatic run_crt(input row_t r);
		int ofs;
		int t;
		loader_pkg::mem_addr_t base;
		clear_mem();
		bt_q.delete();
		bn_q.delete();
		bl_q.delete();
		bs_q.delete();
		@(posedge clk_sys);
		dl_index_i  <= loader_pkg::IDX_CRT;
		dl_active_i <= 1'b1;
		for (ofs = 0; ofs < 'h40; ofs++)
			host_write(ofs, file_hdr_byte(ofs, r));
		for (int p = 0; p < int'(r.npkt); p++) begin
			for (int i = 0; i < 16; i++) begin
				host_write(ofs, chip_hdr_byte(i, r, p));
				ofs = ofs + 1;
			end
			for (int k = 0; k < int'(r.count); k++) begin
				host_write(ofs, data_at(r.seed + loader_pkg::byte_t'(p), k));
				ofs = ofs + 1;
			end
		end
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		t = 0;
		@(negedge clk_sys);
		while (cart_attached_o !== 1'b1) begin
			t = t + 1;
			if (t > HOST_TMO)
				abort_run("timed out waiting for cart_attached_o after the CRT file");
			@(negedge clk_sys);
		end
		check_word("cart_id_o", cart_id_o, r.id);
		check_byte("cart_exrom_o", cart_exrom_o, r.exrom);
		check_byte("cart_game_o", cart_game_o, r.game);
		check_addr("bank_wr_o pulses", loader_pkg::mem_addr_t'(bt_q.size()),
			loader_pkg::mem_addr_t'(r.npkt));
		for (int p = 0; p < int'(r.npkt); p++) begin
			check_byte("bank_type_o", bt_q[p], r.btype);
			check_word("bank_num_o", bn_q[p], loader_pkg::word_t'(p));
			check_word("bank_laddr_o", bl_q[p], r.load);
			check_word("bank_size_o", bs_q[p], r.count);
			// Each packet starts on its own 8 KB boundary
			base = loader_pkg::CRT_BASE + loader_pkg::mem_addr_t'(p * 'h2000);
			for (int k = 0; k < int'(r.count); k++)
				check_once(base + loader_pkg::mem_addr_t'(k),
					data_at(r.seed + loader_pkg::byte_t'(p), k));
		end
		check_addr("crt write count", loader_pkg::mem_addr_t'(total_wr),
			loader_pkg::mem_addr_t'(int'(r.count) * int'(r.npkt)));
	endtask

	initial begin
		RESET       = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		erase_req_i = 1'b0;
		mem_ack_i   = 1'b0;
		seen        = 1'b0;
		delay       = 0;
		total_wr    = 0;

		rows[0] = make_row(loader_pkg::IDX_PRG, 16'h0801, 16'd40, 8'h11, 8'd0);
		rows[1] = make_row(loader_pkg::IDX_CRT, 16'h8000, 16'h0020, 8'h5A, 8'd2);
		rows[1].id    = 16'h0005;
		rows[1].exrom = 8'h00;
		rows[1].game  = 8'h01;
		rows[1].btype = 8'h02;
		rows[2] = make_row(ERASE_KIND, 16'h0000, 16'd0, 8'h00, 8'd0);
		rows[3] = make_row(loader_pkg::IDX_PRG, 16'h1000, 16'd300, 8'hA7, 8'd0);

		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_byte("mem_we_o", loader_pkg::byte_t'(mem_we_o), 8'h00);
		check_byte("dl_wait_o", loader_pkg::byte_t'(dl_wait_o), 8'h00);
		check_byte("bank_wr_o", loader_pkg::byte_t'(bank_wr_o), 8'h00);
		check_byte("busy_o", loader_pkg::byte_t'(busy_o), 8'h00);
		check_byte("cart_attached_o", loader_pkg::byte_t'(cart_attached_o), 8'h00);

		for (int i = 0; i < ROWS; i++) begin
			case (rows[i].kind)
				loader_pkg::IDX_PRG: run_prg(rows[i]);
				loader_pkg::IDX_CRT: run_crt(rows[i]);
				default:             run_erase();
			endcase
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: sources.f
loader_pkg.sv
chip_packet_counter.sv
crt_header_regs.sv
basic_ptr_table.sv
mem_write_port.sv
load_sequencer.sv
loader_top.sv
tb_loader.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_loader
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
